// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --assert --timing --top-module swu_tb -f tb.f -o swu_sim \
   && ./obj_dir/swu_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -q "sim passed" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== swu_chk.sv ====
`timescale 1ns/1ps

module swu_chk (
   input logic           clk,
   input logic           resetn,
   input logic           in_ready_o,
   input swu_pkg::word_t out_data_o,
   input logic           out_valid_o,
   input logic           out_ready_i,
   input logic           out_last_o
);

   // count of failed assertions
   int fail_cnt = 0;

   //////////////////////////////
   // reset state
   //////////////////////////////

   reset_idle_a: assert property (@(posedge clk)
      !resetn |=> !out_valid_o && !out_last_o && in_ready_o)
      else begin
         $error("output stream not idle or input not ready after reset");
         fail_cnt++;
      end

   //////////////////////////////
   // output stream protocol
   //////////////////////////////

   // stalled word holds until the consumer takes it
   out_hold_a: assert property (@(posedge clk) disable iff (!resetn)
      out_valid_o && !out_ready_i |=>
         out_valid_o && $stable(out_data_o) && $stable(out_last_o))
      else begin
         $error("output word changed while stalled");
         fail_cnt++;
      end

   last_valid_a: assert property (@(posedge clk) disable iff (!resetn)
      out_last_o |-> out_valid_o)
      else begin
         $error("last flag without a valid word");
         fail_cnt++;
      end

   // fill and emit never overlap
   fill_emit_a: assert property (@(posedge clk) disable iff (!resetn)
      !(in_ready_o && out_valid_o))
      else begin
         $error("input ready while an output word is valid");
         fail_cnt++;
      end

endmodule

bind swu_top swu_chk u_chk (
   .clk         (clk),
   .resetn      (resetn),
   .in_ready_o  (in_ready_o),
   .out_data_o  (out_data_o),
   .out_valid_o (out_valid_o),
   .out_ready_i (out_ready_i),
   .out_last_o  (out_last_o)
);

// ==== swu_defs.svh ====
`ifndef SWU_DEFS_SVH
`define SWU_DEFS_SVH

//////////////////////////////
// stream word format
//////////////////////////////

// channels carried per word
`define SWU_SIMD       4
// bits per channel
`define SWU_PREC       8

//////////////////////////////
// frame and kernel geometry
//////////////////////////////

`define SWU_IFM_W      5
`define SWU_IFM_H      5
`define SWU_CHANNELS   8
`define SWU_KERNEL     3
`define SWU_STRIDE     1

//////////////////////////////
// derived sizes
//////////////////////////////

// channel groups per pixel
`define SWU_EFF_CH     ((`SWU_CHANNELS) / (`SWU_SIMD))
`define SWU_OFM_W      (((`SWU_IFM_W) - (`SWU_KERNEL)) / (`SWU_STRIDE) + 1)
`define SWU_OFM_H      (((`SWU_IFM_H) - (`SWU_KERNEL)) / (`SWU_STRIDE) + 1)
// words in a whole frame
`define SWU_DEPTH      ((`SWU_IFM_H) * (`SWU_IFM_W) * (`SWU_EFF_CH))
`define SWU_OUT_WORDS  ((`SWU_OFM_W) * (`SWU_OFM_H) * (`SWU_KERNEL) * (`SWU_KERNEL) * (`SWU_EFF_CH))

`endif

// ==== swu_frame_buffer.sv ====
`timescale 1ns/1ps
`include "swu_defs.svh"

module swu_frame_buffer (
   input  logic            clk,
   input  logic            wr_en_i,
   input  swu_pkg::addr_t  wr_addr_i,
   input  swu_pkg::word_t  wr_data_i,
   input  logic            rd_en_i,
   input  swu_pkg::addr_t  rd_addr_i,
   output swu_pkg::word_t  rd_data_o
);
   import swu_pkg::*;

   // one word per frame position
   word_t mem [`SWU_DEPTH];

   //////////////////////////////
   // write port
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   //////////////////////////////
   // read port
   //////////////////////////////

   // read register holds while the pipeline stalls
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== swu_pkg.sv ====
`include "swu_defs.svh"

package swu_pkg;

   //////////////////////////////
   // data and address types
   //////////////////////////////

   typedef logic [`SWU_SIMD*`SWU_PREC-1:0] word_t;
   typedef logic [$clog2(`SWU_DEPTH)-1:0] addr_t;

   // window counter types with room for one extra value
   typedef logic [$clog2(`SWU_EFF_CH+1)-1:0] ch_cnt_t;
   typedef logic [$clog2(`SWU_KERNEL+1)-1:0] k_cnt_t;
   typedef logic [$clog2(`SWU_OFM_W+1)-1:0] ow_cnt_t;
   typedef logic [$clog2(`SWU_OFM_H+1)-1:0] oh_cnt_t;

   //////////////////////////////
   // sequencer state
   //////////////////////////////

   // frame is written in FILL and windows are read out in EMIT
   typedef enum logic {
      FILL,
      EMIT
   } swu_state_e;

endpackage

// ==== swu_read_pipe.sv ====
`timescale 1ns/1ps

module swu_read_pipe (
   input  logic            clk,
   input  logic            resetn,
   input  logic            emit_i,
   input  logic            addr_last_i,
   output logic            issue_o,
   input  swu_pkg::word_t  rd_data_i,
   output swu_pkg::word_t  out_data_o,
   output logic            out_valid_o,
   output logic            out_last_o,
   input  logic            out_ready_i,
   output logic            frame_done_o
);

   logic stall;
   logic last_issued_q;
   logic rd_valid_q;
   logic rd_last_q;

   // output word waiting on the consumer freezes both stages
   assign stall = out_valid_o && !out_ready_i;

   assign issue_o = emit_i && !last_issued_q && !stall;

   // handshake of the last word of the frame
   assign frame_done_o = out_valid_o && out_ready_i && out_last_o;

   //////////////////////////////
   // issue tracking
   //////////////////////////////

   // no read may follow the frame's final address
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_o) begin
         last_issued_q <= 1'b0;
      end else if (issue_o && addr_last_i) begin
         last_issued_q <= 1'b1;
      end
   end

   //////////////////////////////
   // buffer read stage
   //////////////////////////////

   // data itself sits in the frame buffer read register
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_valid_q <= 1'b0;
         rd_last_q  <= 1'b0;
      end else if (!stall) begin
         rd_valid_q <= issue_o;
         rd_last_q  <= issue_o && addr_last_i;
      end
   end

   //////////////////////////////
   // output register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_valid_o <= 1'b0;
         out_last_o  <= 1'b0;
      end else if (!stall) begin
         out_valid_o <= rd_valid_q;
         out_last_o  <= rd_valid_q && rd_last_q;
      end
   end

   // payload register follows the valid flag
   always_ff @(posedge clk) begin
      if (!stall) begin
         out_data_o <= rd_data_i;
      end
   end

endmodule

// ==== swu_sequencer.sv ====
`timescale 1ns/1ps
`include "swu_defs.svh"

module swu_sequencer (
   input  logic            clk,
   input  logic            resetn,
   input  logic            in_valid_i,
   output logic            in_ready_o,
   input  logic            frame_done_i,
   output logic            wr_en_o,
   output swu_pkg::addr_t  wr_addr_o,
   output logic            emit_o
);
   import swu_pkg::*;

   swu_state_e state_q;
   addr_t      wr_addr_q;
   logic       last_write;

   // input only taken while the frame is being filled
   assign in_ready_o = (state_q == FILL);
   assign wr_en_o    = in_valid_i && in_ready_o;
   assign wr_addr_o  = wr_addr_q;
   assign emit_o     = (state_q == EMIT);

   assign last_write = wr_en_o && (wr_addr_q == addr_t'(`SWU_DEPTH - 1));

   //////////////////////////////
   // fill/emit state
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= FILL;
      end else if (state_q == FILL && last_write) begin
         state_q <= EMIT;
      end else if (state_q == EMIT && frame_done_i) begin
         state_q <= FILL;
      end
   end

   //////////////////////////////
   // write address counter
   //////////////////////////////

   // wraps to zero on the last word so the next frame starts at 0
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_addr_q <= '0;
      end else if (last_write) begin
         wr_addr_q <= '0;
      end else if (wr_en_o) begin
         wr_addr_q <= wr_addr_q + 1'b1;
      end
   end

endmodule

// ==== swu_tb.sv ====
`timescale 1ns/1ps
`include "swu_defs.svh"

module swu_tb;
   import swu_pkg::*;

   localparam int CLK_PERIOD  = 4;
   localparam int SEED        = 13;
   localparam int READY_PCT   = 70;
   localparam int GAP_PCT     = 25;
   // frames over all five tests
   localparam int TEST_FRAMES = 7;
   localparam int WATCHDOG_CYCLES =
      4 * TEST_FRAMES * (`SWU_DEPTH + 2 * `SWU_OUT_WORDS) + 5;

   logic  clk = 1'b0;
   logic  resetn;
   word_t in_data_i;
   logic  in_valid_i;
   logic  in_ready_o;
   word_t out_data_o;
   logic  out_valid_o;
   logic  out_ready_i;
   logic  out_last_o;

   int error_cnt = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;

   swu_top u_dut (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .out_last_o  (out_last_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////
   // reference model
   //////////////////////////////

   // input word k of frame f
   function automatic word_t pix_word(int f, int k);
      logic [31:0] v;
      v = (f * 32'h0101_0000) ^ (k * 32'h0000_0301) ^ 32'h5a00_00c3;
      return word_t'(v);
   endfunction

   // frame position of output word j in window order
   function automatic int window_addr(int j);
      int ch;
      int kc;
      int kr;
      int oc;
      int orow;
      int rest;
      ch   = j % `SWU_EFF_CH;
      rest = j / `SWU_EFF_CH;
      kc   = rest % `SWU_KERNEL;
      rest = rest / `SWU_KERNEL;
      kr   = rest % `SWU_KERNEL;
      rest = rest / `SWU_KERNEL;
      oc   = rest % `SWU_OFM_W;
      orow = rest / `SWU_OFM_W;
      return ((orow * `SWU_STRIDE + kr) * `SWU_IFM_W + oc * `SWU_STRIDE + kc)
             * `SWU_EFF_CH + ch;
   endfunction

   task automatic check_value(string name, word_t exp, word_t act);
      if (exp !== act) begin
         $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
         error_cnt++;
      end
   endtask

   function automatic int errors_so_far();
      return error_cnt + u_dut.u_chk.fail_cnt;
   endfunction

   task automatic report_test(int num, string name, int errs_before);
      if (errors_so_far() == errs_before) begin
         $display("test %0d %s: PASS", num, name);
         pass_cnt++;
      end else begin
         $display("test %0d %s: FAIL", num, name);
         fail_cnt++;
      end
   endtask

   //////////////////////////////
   // stream drivers
   //////////////////////////////

   // a word is taken when in_ready_o is high at the falling edge
   task automatic feed_frames(int first_f, int n_frames, bit gaps, bit junk);
      logic accepted;
      for (int f = first_f; f < first_f + n_frames; f++) begin
         for (int k = 0; k < `SWU_DEPTH; k++) begin
            while (gaps && $urandom_range(0, 99) < GAP_PCT) begin
               in_valid_i = 1'b0;
               @(negedge clk);
            end
            in_data_i  = pix_word(f, k);
            in_valid_i = 1'b1;
            do begin
               accepted = in_ready_o;
               @(negedge clk);
            end while (!accepted);
         end
         in_valid_i = 1'b0;
         // junk offered all through emit is never written
         if (junk) begin
            while (!in_ready_o) begin
               in_data_i  = word_t'($urandom());
               in_valid_i = 1'b1;
               @(negedge clk);
            end
            in_valid_i = 1'b0;
         end
      end
   endtask

   task automatic collect_frames(int first_f, int n_frames, bit bp);
      int j;
      int idx;
      j = 0;
      while (j < n_frames * `SWU_OUT_WORDS) begin
         out_ready_i = bp ? ($urandom_range(0, 99) < READY_PCT) : 1'b1;
         if (out_valid_o && out_ready_i) begin
            idx = j % `SWU_OUT_WORDS;
            check_value("out_data_o",
               pix_word(first_f + j / `SWU_OUT_WORDS, window_addr(idx)), out_data_o);
            check_value("out_last_o",
               word_t'(idx == `SWU_OUT_WORDS - 1), word_t'(out_last_o));
            j++;
         end
         @(negedge clk);
      end
   endtask

   task automatic run_frames(int first_f, int n_frames, bit gaps, bit bp, bit junk);
      fork
         feed_frames(first_f, n_frames, gaps, junk);
         collect_frames(first_f, n_frames, bp);
      join
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      int errs;
      void'($urandom(SEED));
      resetn      = 1'b0;
      in_data_i   = '0;
      in_valid_i  = 1'b0;
      out_ready_i = 1'b0;
      repeat (5) @(negedge clk);
      resetn = 1'b1;

      errs = errors_so_far();
      check_value("out_valid_o", word_t'(1'b0), word_t'(out_valid_o));
      check_value("out_last_o", word_t'(1'b0), word_t'(out_last_o));
      check_value("in_ready_o", word_t'(1'b1), word_t'(in_ready_o));
      report_test(1, "reset state", errs);

      errs = errors_so_far();
      run_frames(0, 1, 1'b0, 1'b0, 1'b0);
      report_test(2, "full rate frame", errs);

      errs = errors_so_far();
      run_frames(1, 1, 1'b1, 1'b1, 1'b0);
      report_test(3, "back-pressure and input gaps", errs);

      errs = errors_so_far();
      run_frames(2, 2, 1'b0, 1'b0, 1'b1);
      report_test(4, "input blocked during emit", errs);

      errs = errors_so_far();
      run_frames(4, 3, 1'b0, 1'b1, 1'b0);
      report_test(5, "back-to-back frames", errs);

      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: the DUT did not complete the tests in time");
      $display("sim failed");
      $finish;
   end

endmodule

// ==== swu_top.sv ====
`timescale 1ns/1ps

module swu_top (
   input  logic            clk,
   input  logic            resetn,
   input  swu_pkg::word_t  in_data_i,
   input  logic            in_valid_i,
   output logic            in_ready_o,
   output swu_pkg::word_t  out_data_o,
   output logic            out_valid_o,
   input  logic            out_ready_i,
   output logic            out_last_o
);
   import swu_pkg::*;

   logic  wr_en;
   addr_t wr_addr;
   logic  emit;
   logic  issue;
   addr_t rd_addr;
   logic  addr_last;
   word_t rd_data;
   logic  frame_done;

   //////////////////////////////
   // write side
   //////////////////////////////

   swu_sequencer u_sequencer (
      .clk          (clk),
      .resetn       (resetn),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .frame_done_i (frame_done),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .emit_o       (emit)
   );

   // write data comes straight from the input stream
   swu_frame_buffer u_frame_buffer (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (in_data_i),
      .rd_en_i   (issue),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   //////////////////////////////
   // read side
   //////////////////////////////

   swu_window_gen u_window_gen (
      .clk          (clk),
      .resetn       (resetn),
      .advance_i    (issue),
      .frame_done_i (frame_done),
      .rd_addr_o    (rd_addr),
      .last_o       (addr_last)
   );

   swu_read_pipe u_read_pipe (
      .clk          (clk),
      .resetn       (resetn),
      .emit_i       (emit),
      .addr_last_i  (addr_last),
      .issue_o      (issue),
      .rd_data_i    (rd_data),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o),
      .out_last_o   (out_last_o),
      .out_ready_i  (out_ready_i),
      .frame_done_o (frame_done)
   );

endmodule

// ==== swu_window_gen.sv ====
`timescale 1ns/1ps
`include "swu_defs.svh"

module swu_window_gen (
   input  logic            clk,
   input  logic            resetn,
   input  logic            advance_i,
   input  logic            frame_done_i,
   output swu_pkg::addr_t  rd_addr_o,
   output logic            last_o
);
   import swu_pkg::*;

   ch_cnt_t ch_q;
   k_cnt_t  kc_q;
   k_cnt_t  kr_q;
   ow_cnt_t oc_q;
   oh_cnt_t orow_q;

   logic ch_end;
   logic kc_end;
   logic kr_end;
   logic oc_end;
   logic orow_end;

   addr_t pix_row;
   addr_t pix_col;

   //////////////////////////////
   // counter end flags
   //////////////////////////////

   assign ch_end   = (ch_q == ch_cnt_t'(`SWU_EFF_CH - 1));
   assign kc_end   = (kc_q == k_cnt_t'(`SWU_KERNEL - 1));
   assign kr_end   = (kr_q == k_cnt_t'(`SWU_KERNEL - 1));
   assign oc_end   = (oc_q == ow_cnt_t'(`SWU_OFM_W - 1));
   assign orow_end = (orow_q == oh_cnt_t'(`SWU_OFM_H - 1));

   // final word of the final window
   assign last_o = ch_end && kc_end && kr_end && oc_end && orow_end;

   //////////////////////////////
   // window counter nest
   //////////////////////////////

   // channel group innermost, then kernel col, kernel row, out col and out row
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         ch_q   <= '0;
         kc_q   <= '0;
         kr_q   <= '0;
         oc_q   <= '0;
         orow_q <= '0;
      end else if (advance_i) begin
         if (!ch_end) begin
            ch_q <= ch_q + 1'b1;
         end else begin
            ch_q <= '0;
            if (!kc_end) begin
               kc_q <= kc_q + 1'b1;
            end else begin
               kc_q <= '0;
               if (!kr_end) begin
                  kr_q <= kr_q + 1'b1;
               end else begin
                  kr_q <= '0;
                  if (!oc_end) begin
                     oc_q <= oc_q + 1'b1;
                  end else begin
                     oc_q <= '0;
                     if (!orow_end) begin
                        orow_q <= orow_q + 1'b1;
                     end else begin
                        orow_q <= '0;
                     end
                  end
               end
            end
         end
      end
   end

   //////////////////////////////
   // read address
   //////////////////////////////

   // input pixel row and column under the current kernel tap
   assign pix_row = addr_t'(orow_q) * addr_t'(`SWU_STRIDE) + addr_t'(kr_q);
   assign pix_col = addr_t'(oc_q) * addr_t'(`SWU_STRIDE) + addr_t'(kc_q);

   // pixels are stored row major with channel groups innermost
   assign rd_addr_o = (pix_row * addr_t'(`SWU_IFM_W) + pix_col) * addr_t'(`SWU_EFF_CH)
                      + addr_t'(ch_q);

endmodule

// ==== tb.f ====
+incdir+.
swu_pkg.sv
swu_frame_buffer.sv
swu_sequencer.sv
swu_window_gen.sv
swu_read_pipe.sv
swu_top.sv
swu_chk.sv
swu_tb.sv
